//--- verilog.f
saturn_pkg.sv
saturn_reg_file.sv
saturn_field_alu.sv
saturn_cmd_input.sv
saturn_bus_sender.sv
saturn_core.sv
tb_saturn_core.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it into sim.log and
# decides pass or fail from the log.
rm -f sim.log
verilator --binary --timing -f verilog.f --top-module tb_saturn_core \
    --Mdir obj_dir -o tb_saturn_core || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_saturn_core > sim.log 2>&1 || echo "simulator exited with an error status"
cat sim.log
grep -q "tests failed" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "all tests passed" sim.log || { echo "RESULT: FAIL (no pass line)"; exit 1; }
echo "RESULT: PASS"

//--- tb_saturn_core.sv
//////////////////////////////////////////////////////////////
// Self-checking testbench for the Saturn field datapath. Runs
// directed and random field commands and CONFIG programs and
// compares registers and bus words with a reference model.
//////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_saturn_core;
    import saturn_pkg::*;

    localparam int N_CMDS         = 62;  // Commands issued by the directed and random parts.
    localparam int CMD_CYCLES     = 64;  // Generous bound for one command under back-pressure.
    localparam int READ_CYCLES    = 4 * REG_NIBBLES + 2;
    localparam int TIMEOUT_CYCLES = REG_NIBBLES + 8 + N_CMDS * (CMD_CYCLES + READ_CYCLES);

    logic        i_clk = 1'b0;
    logic        i_reset;
    logic        i_cmd_valid;
    logic        o_cmd_ready;
    alu_op_e     i_cmd_op;
    reg_sel_e    i_cmd_dest;
    reg_sel_e    i_cmd_src_1;
    reg_sel_e    i_cmd_src_2;
    nibble_ptr_t i_cmd_begin;
    nibble_ptr_t i_cmd_end;
    nibble_t     i_cmd_imm;
    logic        o_bus_valid;
    bus_word_t   o_bus_word;
    logic        i_bus_ready = 1'b0;
    reg_sel_e    i_dbg_reg;
    nibble_ptr_t i_dbg_ptr;
    nibble_t     o_dbg_nibble;

    nibble_t     model [0:3][0:REG_NIBBLES-1]; // Expected contents of A to D.
    bus_word_t   exp_words [$];                 // Every bus word expected since reset.
    int          words_seen  = 0;
    int          cycle_count = 0;
    logic [31:0] stim_lfsr   = 32'h849a;
    logic [31:0] ready_lfsr  = 32'h849a;

    saturn_core dut_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_cmd_valid  (i_cmd_valid),
        .o_cmd_ready  (o_cmd_ready),
        .i_cmd_op     (i_cmd_op),
        .i_cmd_dest   (i_cmd_dest),
        .i_cmd_src_1  (i_cmd_src_1),
        .i_cmd_src_2  (i_cmd_src_2),
        .i_cmd_begin  (i_cmd_begin),
        .i_cmd_end    (i_cmd_end),
        .i_cmd_imm    (i_cmd_imm),
        .o_bus_valid  (o_bus_valid),
        .o_bus_word   (o_bus_word),
        .i_bus_ready  (i_bus_ready),
        .i_dbg_reg    (i_dbg_reg),
        .i_dbg_ptr    (i_dbg_ptr),
        .o_dbg_nibble (o_dbg_nibble)
    );

    always #4 i_clk = ~i_clk;

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic void random_fields(output reg_sel_e dest, output reg_sel_e src_1,
            output reg_sel_e src_2, output nibble_ptr_t fb, output nibble_ptr_t fe,
            output nibble_t imm);
        nibble_ptr_t a;
        nibble_ptr_t b;
        dest  = reg_sel_e'(take_bits(2));
        src_1 = reg_sel_e'(take_bits(2));
        src_2 = reg_sel_e'(take_bits(2));
        a     = nibble_ptr_t'(take_bits(4));
        b     = nibble_ptr_t'(take_bits(4));
        fb    = (a < b) ? a : b; // The field always runs upward.
        fe    = (a < b) ? b : a;
        imm   = nibble_t'(take_bits(4));
    endfunction

    // Applies one field operation to the model registers.
    function automatic void apply_ref(input alu_op_e op, input reg_sel_e dest,
            input reg_sel_e src_1, input reg_sel_e src_2, input nibble_ptr_t fb,
            input nibble_ptr_t fe, input nibble_t imm);
        nibble_t tmp;
        for (int i = int'(fb); i <= int'(fe); i++) begin
            case (op)
                OP_ZERO: model[dest][i[3:0]] = 4'h0;
                OP_COPY: model[dest][i[3:0]] = model[src_1][i[3:0]];
                OP_EXCH: begin
                    tmp                   = model[dest][i[3:0]];
                    model[dest][i[3:0]]   = model[src_2][i[3:0]];
                    model[src_2][i[3:0]]  = tmp;
                end
                OP_LOAD: model[dest][i[3:0]] = imm;
                default: ;
            endcase
        end
    endfunction

    // CONFIGURE, C nibbles 0 to 4 as data words, then PC_READ.
    function automatic void expect_config();
        exp_words.push_back({2'b01, BUSCMD_CONFIGURE});
        for (int k = 0; k < ADDR_NIBBLES; k++) begin
            exp_words.push_back({2'b00, model[REG_C][k[3:0]]});
        end
        exp_words.push_back({2'b01, BUSCMD_PC_READ});
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_nibble(input string name, input nibble_t expected,
            input nibble_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h",
                                    name, expected, actual));
        end
    endtask

    task automatic check_bus_word(input string name, input bus_word_t expected,
            input bus_word_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h",
                                    name, expected, actual));
        end
    endtask

    task automatic wait_idle();
        @(negedge i_clk);
        while (!o_cmd_ready) @(negedge i_clk);
    endtask

    task automatic issue_cmd(input alu_op_e op, input reg_sel_e dest, input reg_sel_e src_1,
            input reg_sel_e src_2, input nibble_ptr_t fb, input nibble_ptr_t fe,
            input nibble_t imm);
        @(posedge i_clk);
        i_cmd_valid <= 1'b1;
        i_cmd_op    <= op;
        i_cmd_dest  <= dest;
        i_cmd_src_1 <= src_1;
        i_cmd_src_2 <= src_2;
        i_cmd_begin <= fb;
        i_cmd_end   <= fe;
        i_cmd_imm   <= imm;
        wait_idle();
        @(posedge i_clk);  // The command transfers on this edge.
        i_cmd_valid <= 1'b0;
        if (op == OP_CONFIG) begin
            expect_config();
        end else begin
            apply_ref(op, dest, src_1, src_2, fb, fe, imm);
        end
    endtask

    // Reads all 64 nibbles through the debug port.
    task automatic check_regs(input string name);
        for (int r = 0; r < 4; r++) begin
            for (int p = 0; p < REG_NIBBLES; p++) begin
                @(posedge i_clk);
                i_dbg_reg <= reg_sel_e'(r);
                i_dbg_ptr <= nibble_ptr_t'(p);
                @(negedge i_clk);
                check_nibble($sformatf("%s reg %0d nibble %0d", name, r, p),
                             model[r[1:0]][p[3:0]], o_dbg_nibble);
            end
        end
    endtask

    task automatic run_checked(input string name, input alu_op_e op, input reg_sel_e dest,
            input reg_sel_e src_1, input reg_sel_e src_2, input nibble_ptr_t fb,
            input nibble_ptr_t fe, input nibble_t imm);
        issue_cmd(op, dest, src_1, src_2, fb, fe, imm);
        wait_idle();
        if (words_seen != exp_words.size()) begin
            stop_on_error($sformatf("%s: CONFIG finished after %0d of %0d bus words.",
                                    name, words_seen, exp_words.size()));
        end
        check_regs(name);
    endtask

    always @(posedge i_clk) begin
        ready_lfsr = lfsr_next(ready_lfsr);
        i_bus_ready <= ready_lfsr[0];  // Random back-pressure on the bus.
    end

    // Every offered word must belong to a CONFIG program that is under way.
    always @(negedge i_clk) begin
        if (!i_reset && o_bus_valid) begin
            if (words_seen >= exp_words.size()) begin
                stop_on_error("Bus valid went high with no CONFIG word outstanding.");
            end else if (i_bus_ready) begin
                check_bus_word($sformatf("config word %0d", words_seen % 7),
                               exp_words[words_seen], o_bus_word);
                words_seen = words_seen + 1;
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("Run did not finish within %0d cycles.", TIMEOUT_CYCLES));
        end
    end

    initial begin
        alu_op_e     op;
        reg_sel_e    d;
        reg_sel_e    s1;
        reg_sel_e    s2;
        reg_sel_e    exch_dest;
        nibble_ptr_t fb;
        nibble_ptr_t fe;
        nibble_t     imm;
        i_reset     = 1'b1;
        i_cmd_valid = 1'b0;
        i_cmd_op    = OP_ZERO;
        i_cmd_dest  = REG_A;
        i_cmd_src_1 = REG_A;
        i_cmd_src_2 = REG_A;
        i_cmd_begin = '0;
        i_cmd_end   = '0;
        i_cmd_imm   = '0;
        i_dbg_reg   = REG_A;
        i_dbg_ptr   = '0;
        for (int r = 0; r < 4; r++) begin
            for (int p = 0; p < REG_NIBBLES; p++) begin
                model[r][p] = 4'h0;
            end
        end
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        if (o_cmd_ready || o_bus_valid) begin
            stop_on_error("Command ready or bus valid was high during the register sweep.");
        end
        wait_idle();
        check_regs("reset");

        for (int n = 0; n < 8; n++) begin
            random_fields(d, s1, s2, fb, fe, imm);
            run_checked("load", OP_LOAD, reg_sel_e'(n % 4), s1, s2, fb, fe, imm);
        end
        for (int n = 0; n < 4; n++) begin
            random_fields(d, s1, s2, fb, fe, imm);
            if (n == 0) s1 = d;  // Copy a field onto itself.
            run_checked("copy", OP_COPY, d, s1, s2, fb, fe, imm);
        end
        for (int n = 0; n < 2; n++) begin
            random_fields(d, s1, s2, fb, fe, imm);
            run_checked("zero", OP_ZERO, d, s1, s2, fb, fe, imm);
        end
        for (int n = 0; n < 3; n++) begin
            random_fields(d, s1, s2, fb, fe, imm);
            if (s2 == d) s2 = reg_sel_e'(~d);  // Swap between two different registers.
            run_checked("exch", OP_EXCH, d, s1, s2, fb, fe, imm);
        end

        // The COPY waits on the EXCH and reads the field it just wrote.
        random_fields(d, s1, s2, fb, fe, imm);
        exch_dest = d;
        issue_cmd(OP_EXCH, d, s1, s2, fb, fe, imm);
        d = reg_sel_e'(take_bits(2));
        run_checked("back-to-back", OP_COPY, d, exch_dest, s2, fb, fe, imm);

        for (int n = 0; n < 3; n++) begin
            random_fields(d, s1, s2, fb, fe, imm);
            run_checked("config", OP_CONFIG, d, s1, s2, fb, fe, imm);
        end
        for (int n = 0; n < 40; n++) begin
            op = alu_op_e'(take_bits(3) % 5);
            random_fields(d, s1, s2, fb, fe, imm);
            run_checked("random", op, d, s1, s2, fb, fe, imm);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- saturn_core.sv
//////////////////////////////////////////////////////////////
// Top level of the Saturn field datapath. Wires the command
// input, field ALU, register file and bus sender together.
//////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module saturn_core (
    input  logic                   i_clk,
    input  logic                   i_reset,

    input  logic                   i_cmd_valid,
    output logic                   o_cmd_ready,
    input  saturn_pkg::alu_op_e     i_cmd_op,
    input  saturn_pkg::reg_sel_e    i_cmd_dest,
    input  saturn_pkg::reg_sel_e    i_cmd_src_1,
    input  saturn_pkg::reg_sel_e    i_cmd_src_2,
    input  saturn_pkg::nibble_ptr_t i_cmd_begin,
    input  saturn_pkg::nibble_ptr_t i_cmd_end,
    input  saturn_pkg::nibble_t     i_cmd_imm,

    output logic                   o_bus_valid,
    output saturn_pkg::bus_word_t   o_bus_word,
    input  logic                   i_bus_ready,

    input  saturn_pkg::reg_sel_e    i_dbg_reg,
    input  saturn_pkg::nibble_ptr_t i_dbg_ptr,
    output saturn_pkg::nibble_t     o_dbg_nibble
);
    import saturn_pkg::*;

    logic        init_done;
    logic        alu_start;
    logic        cfg_start;
    logic        alu_done;
    logic        cfg_done;
    alu_op_e     op;
    reg_sel_e    dest;
    reg_sel_e    src_1;
    reg_sel_e    src_2;
    nibble_ptr_t field_begin;
    nibble_ptr_t field_end;
    nibble_t     imm;

    reg_sel_e    rd_reg_1;
    reg_sel_e    rd_reg_2;
    nibble_ptr_t rd_ptr;
    nibble_t     rd_nibble_1;
    nibble_t     rd_nibble_2;
    logic        wr_en_1;
    logic        wr_en_2;
    reg_sel_e    wr_reg_1;
    reg_sel_e    wr_reg_2;
    nibble_ptr_t wr_ptr;
    nibble_t     wr_nibble_1;
    nibble_t     wr_nibble_2;
    nibble_ptr_t c_ptr;
    nibble_t     c_nibble;

    saturn_cmd_input cmd_input_i (
        .i_clk       (i_clk),       .i_reset     (i_reset),
        .i_init_done (init_done),
        .i_cmd_valid (i_cmd_valid), .o_cmd_ready (o_cmd_ready),
        .i_cmd_op    (i_cmd_op),    .i_cmd_dest  (i_cmd_dest),
        .i_cmd_src_1 (i_cmd_src_1), .i_cmd_src_2 (i_cmd_src_2),
        .i_cmd_begin (i_cmd_begin), .i_cmd_end   (i_cmd_end),
        .i_cmd_imm   (i_cmd_imm),
        .o_alu_start (alu_start),   .o_cfg_start (cfg_start),
        .o_op        (op),          .o_dest      (dest),
        .o_src_1     (src_1),       .o_src_2     (src_2),
        .o_begin     (field_begin), .o_end       (field_end),
        .o_imm       (imm),
        .i_alu_done  (alu_done),    .i_cfg_done  (cfg_done)
    );

    saturn_field_alu field_alu_i (
        .i_clk         (i_clk),       .i_reset       (i_reset),
        .i_start       (alu_start),   .i_op          (op),
        .i_dest        (dest),        .i_src_1       (src_1),
        .i_src_2       (src_2),       .i_begin       (field_begin),
        .i_end         (field_end),   .i_imm         (imm),
        .o_rd_reg_1    (rd_reg_1),    .o_rd_reg_2    (rd_reg_2),
        .o_rd_ptr      (rd_ptr),
        .i_rd_nibble_1 (rd_nibble_1), .i_rd_nibble_2 (rd_nibble_2),
        .o_wr_en_1     (wr_en_1),     .o_wr_en_2     (wr_en_2),
        .o_wr_reg_1    (wr_reg_1),    .o_wr_reg_2    (wr_reg_2),
        .o_wr_ptr      (wr_ptr),
        .o_wr_nibble_1 (wr_nibble_1), .o_wr_nibble_2 (wr_nibble_2),
        .o_done        (alu_done)
    );

    saturn_reg_file reg_file_i (
        .i_clk         (i_clk),       .i_reset       (i_reset),
        .o_init_done   (init_done),
        .i_rd_reg_1    (rd_reg_1),    .i_rd_reg_2    (rd_reg_2),
        .i_rd_ptr      (rd_ptr),
        .o_rd_nibble_1 (rd_nibble_1), .o_rd_nibble_2 (rd_nibble_2),
        .i_c_ptr       (c_ptr),       .o_c_nibble    (c_nibble),
        .i_wr_en_1     (wr_en_1),     .i_wr_en_2     (wr_en_2),
        .i_wr_reg_1    (wr_reg_1),    .i_wr_reg_2    (wr_reg_2),
        .i_wr_ptr      (wr_ptr),
        .i_wr_nibble_1 (wr_nibble_1), .i_wr_nibble_2 (wr_nibble_2),
        .i_dbg_reg     (i_dbg_reg),   .i_dbg_ptr     (i_dbg_ptr),
        .o_dbg_nibble  (o_dbg_nibble)
    );

    saturn_bus_sender bus_sender_i (
        .i_clk       (i_clk),       .i_reset     (i_reset),
        .i_start     (cfg_start),
        .o_c_ptr     (c_ptr),       .i_c_nibble  (c_nibble),
        .o_bus_valid (o_bus_valid), .o_bus_word  (o_bus_word),
        .i_bus_ready (i_bus_ready),
        .o_done      (cfg_done)
    );

endmodule

`default_nettype wire

//--- saturn_bus_sender.sv
//////////////////////////////////////////////////////////////
// Bus sender for CONFIG. Streams CONFIGURE, C nibbles 0 to 4
// and PC_READ as 6-bit words on a valid/ready port.
//////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module saturn_bus_sender (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_start,

    output saturn_pkg::nibble_ptr_t o_c_ptr,
    input  saturn_pkg::nibble_t     i_c_nibble,

    output logic                   o_bus_valid,
    output saturn_pkg::bus_word_t   o_bus_word,
    input  logic                   i_bus_ready,

    output logic                   o_done
);
    import saturn_pkg::*;

    localparam logic [2:0] LAST_WORD = 3'(ADDR_NIBBLES + 1); // Index of PC_READ.

    logic       busy;
    logic [2:0] word_cnt;
    logic       accept;

    assign o_bus_valid = busy;
    assign accept      = busy && i_bus_ready;
    assign o_done      = accept && (word_cnt == LAST_WORD);

    // Words 1 to 5 carry C nibbles 0 to 4. C is read live since nothing writes it now.
    assign o_c_ptr = nibble_ptr_t'(word_cnt - 3'd1);

    always_comb begin
        if (word_cnt == 3'd0) begin
            o_bus_word = {BUS_TAG_CMD, BUSCMD_CONFIGURE};
        end else if (word_cnt == LAST_WORD) begin
            o_bus_word = {BUS_TAG_CMD, BUSCMD_PC_READ};
        end else begin
            o_bus_word = {BUS_TAG_DATA, i_c_nibble};
        end
    end

    // The counter only moves on an accepted word.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            busy     <= 1'b0;
            word_cnt <= '0;
        end else if (i_start) begin
            busy     <= 1'b1;
            word_cnt <= '0;
        end else if (accept) begin
            if (word_cnt == LAST_WORD) begin
                busy <= 1'b0;
            end else begin
                word_cnt <= word_cnt + 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- saturn_cmd_input.sv
//////////////////////////////////////////////////////////////
// Command input. Takes one command at a time on valid/ready,
// holds its fields and starts the field ALU or bus sender.
//////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module saturn_cmd_input (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_init_done,

    input  logic                   i_cmd_valid,
    output logic                   o_cmd_ready,
    input  saturn_pkg::alu_op_e     i_cmd_op,
    input  saturn_pkg::reg_sel_e    i_cmd_dest,
    input  saturn_pkg::reg_sel_e    i_cmd_src_1,
    input  saturn_pkg::reg_sel_e    i_cmd_src_2,
    input  saturn_pkg::nibble_ptr_t i_cmd_begin,
    input  saturn_pkg::nibble_ptr_t i_cmd_end,
    input  saturn_pkg::nibble_t     i_cmd_imm,

    output logic                   o_alu_start,
    output logic                   o_cfg_start,
    output saturn_pkg::alu_op_e     o_op,
    output saturn_pkg::reg_sel_e    o_dest,
    output saturn_pkg::reg_sel_e    o_src_1,
    output saturn_pkg::reg_sel_e    o_src_2,
    output saturn_pkg::nibble_ptr_t o_begin,
    output saturn_pkg::nibble_ptr_t o_end,
    output saturn_pkg::nibble_t     o_imm,

    input  logic                   i_alu_done,
    input  logic                   i_cfg_done
);
    import saturn_pkg::*;

    typedef enum logic [1:0] {
        ST_INIT,   // Waiting for the register sweep.
        ST_IDLE,
        ST_BUSY
    } state_e;

    state_e state;
    logic   take;

    assign o_cmd_ready = (state == ST_IDLE);
    assign take        = i_cmd_valid && o_cmd_ready;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state       <= ST_INIT;
            o_alu_start <= 1'b0;
            o_cfg_start <= 1'b0;
        end else begin
            o_alu_start <= take && (i_cmd_op != OP_CONFIG);
            o_cfg_start <= take && (i_cmd_op == OP_CONFIG);
            case (state)
                ST_INIT: if (i_init_done) state <= ST_IDLE;
                ST_IDLE: if (take) state <= ST_BUSY;
                ST_BUSY: if (i_alu_done || i_cfg_done) state <= ST_IDLE;
                default: state <= ST_INIT;
            endcase
        end
    end

    // Fields stay put until the started block reports done.
    always_ff @(posedge i_clk) begin
        if (take) begin
            o_op    <= i_cmd_op;
            o_dest  <= i_cmd_dest;
            o_src_1 <= i_cmd_src_1;
            o_src_2 <= i_cmd_src_2;
            o_begin <= i_cmd_begin;
            o_end   <= i_cmd_end;
            o_imm   <= i_cmd_imm;
        end
    end

endmodule

`default_nettype wire

//--- saturn_field_alu.sv
//////////////////////////////////////////////////////////////
// Field ALU. Runs one field operation as a prepare, calculate
// and save pipeline, one nibble per stage per cycle.
//////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module saturn_field_alu (
    input  logic                   i_clk,
    input  logic                   i_reset,

    input  logic                   i_start,
    input  saturn_pkg::alu_op_e     i_op,
    input  saturn_pkg::reg_sel_e    i_dest,
    input  saturn_pkg::reg_sel_e    i_src_1,
    input  saturn_pkg::reg_sel_e    i_src_2,
    input  saturn_pkg::nibble_ptr_t i_begin,
    input  saturn_pkg::nibble_ptr_t i_end,
    input  saturn_pkg::nibble_t     i_imm,

    output saturn_pkg::reg_sel_e    o_rd_reg_1,
    output saturn_pkg::reg_sel_e    o_rd_reg_2,
    output saturn_pkg::nibble_ptr_t o_rd_ptr,
    input  saturn_pkg::nibble_t     i_rd_nibble_1,
    input  saturn_pkg::nibble_t     i_rd_nibble_2,

    output logic                   o_wr_en_1,
    output logic                   o_wr_en_2,
    output saturn_pkg::reg_sel_e    o_wr_reg_1,
    output saturn_pkg::reg_sel_e    o_wr_reg_2,
    output saturn_pkg::nibble_ptr_t o_wr_ptr,
    output saturn_pkg::nibble_t     o_wr_nibble_1,
    output saturn_pkg::nibble_t     o_wr_nibble_2,

    output logic                   o_done
);
    import saturn_pkg::*;

    // The command fields are held steady by the command input until o_done.
    logic        is_exch;
    logic        prep_act;
    nibble_ptr_t prep_ptr;
    logic        prep_run;
    nibble_ptr_t prep_pos;
    nibble_t     src_1_q;
    nibble_t     src_2_q;
    logic        calc_run;
    nibble_ptr_t calc_pos;
    nibble_t     res_1_q;
    nibble_t     res_2_q;
    logic        save_run;
    nibble_ptr_t save_pos;

    assign is_exch  = (i_op == OP_EXCH);
    assign prep_act = i_start || prep_run;       // Prepare reads the first nibble on start.
    assign prep_ptr = prep_run ? prep_pos : i_begin;

    // An exchange reads the destination on port 1, so it swaps dest with src 2.
    assign o_rd_reg_1 = is_exch ? i_dest : i_src_1;
    assign o_rd_reg_2 = i_src_2;
    assign o_rd_ptr   = prep_ptr;

    assign o_wr_en_1     = save_run;
    assign o_wr_en_2     = save_run && is_exch;
    assign o_wr_reg_1    = i_dest;
    assign o_wr_reg_2    = i_src_2;
    assign o_wr_ptr      = save_pos;
    assign o_wr_nibble_1 = res_1_q;
    assign o_wr_nibble_2 = res_2_q;
    assign o_done        = save_run && (save_pos == i_end);

    // Each stage is kicked by the one before it and stops at the end pointer.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            prep_run <= 1'b0;
            calc_run <= 1'b0;
            save_run <= 1'b0;
        end else begin
            if (prep_act) begin
                prep_run <= (prep_ptr != i_end);
            end
            if (prep_act) begin
                calc_run <= 1'b1;
            end else if (calc_run && (calc_pos == i_end)) begin
                calc_run <= 1'b0;
            end
            if (calc_run) begin
                save_run <= 1'b1;
            end else if (save_run && (save_pos == i_end)) begin
                save_run <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (prep_act) begin
            prep_pos <= prep_ptr + 4'd1;
            src_1_q  <= i_rd_nibble_1;
            src_2_q  <= i_rd_nibble_2;
        end
        if (i_start) begin
            calc_pos <= i_begin;
            save_pos <= i_begin;
        end else begin
            if (calc_run) begin
                calc_pos <= calc_pos + 4'd1;
            end
            if (save_run) begin
                save_pos <= save_pos + 4'd1;
            end
        end
        if (calc_run) begin
            case (i_op)
                OP_COPY: res_1_q <= src_1_q;
                OP_EXCH: begin
                    res_1_q <= src_2_q;   // Goes to the destination.
                    res_2_q <= src_1_q;   // Goes back to source 2.
                end
                OP_LOAD: res_1_q <= i_imm;
                default: res_1_q <= '0;   // ZERO needs no source nibbles.
            endcase
        end
    end

endmodule

`default_nettype wire

//--- saturn_reg_file.sv
//////////////////////////////////////////////////////////////
// Working registers A to D, sixteen nibbles each. Cleared by
// a sweep after reset, then read combinationally and written
// on the clock by the field ALU.
//////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module saturn_reg_file (
    input  logic                   i_clk,
    input  logic                   i_reset,
    output logic                   o_init_done,

    input  saturn_pkg::reg_sel_e    i_rd_reg_1,
    input  saturn_pkg::reg_sel_e    i_rd_reg_2,
    input  saturn_pkg::nibble_ptr_t i_rd_ptr,
    output saturn_pkg::nibble_t     o_rd_nibble_1,
    output saturn_pkg::nibble_t     o_rd_nibble_2,

    input  saturn_pkg::nibble_ptr_t i_c_ptr,
    output saturn_pkg::nibble_t     o_c_nibble,

    input  logic                   i_wr_en_1,
    input  logic                   i_wr_en_2,
    input  saturn_pkg::reg_sel_e    i_wr_reg_1,
    input  saturn_pkg::reg_sel_e    i_wr_reg_2,
    input  saturn_pkg::nibble_ptr_t i_wr_ptr,
    input  saturn_pkg::nibble_t     i_wr_nibble_1,
    input  saturn_pkg::nibble_t     i_wr_nibble_2,

    input  saturn_pkg::reg_sel_e    i_dbg_reg,
    input  saturn_pkg::nibble_ptr_t i_dbg_ptr,
    output saturn_pkg::nibble_t     o_dbg_nibble
);
    import saturn_pkg::*;

    localparam nibble_ptr_t LAST_PTR = nibble_ptr_t'(REG_NIBBLES - 1);

    nibble_t     regs [0:3][0:REG_NIBBLES-1]; // Indexed by reg_sel_e, then nibble.
    nibble_ptr_t init_ptr;

    assign o_rd_nibble_1 = regs[i_rd_reg_1][i_rd_ptr];
    assign o_rd_nibble_2 = regs[i_rd_reg_2][i_rd_ptr];
    assign o_c_nibble    = regs[REG_C][i_c_ptr]; // The bus sender only ever reads C.
    assign o_dbg_nibble  = regs[i_dbg_reg][i_dbg_ptr];

    // One nibble position of all four registers is cleared per cycle.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            init_ptr    <= '0;
            o_init_done <= 1'b0;
        end else if (!o_init_done) begin
            init_ptr <= init_ptr + 4'd1;
            if (init_ptr == LAST_PTR) begin
                o_init_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!o_init_done) begin
            for (int r = 0; r < 4; r++) begin
                regs[r][init_ptr] <= '0;
            end
        end else begin
            if (i_wr_en_1) begin
                regs[i_wr_reg_1][i_wr_ptr] <= i_wr_nibble_1;
            end
            // Port 2 is the second register of an exchange.
            if (i_wr_en_2) begin
                regs[i_wr_reg_2][i_wr_ptr] <= i_wr_nibble_2;
            end
        end
    end

endmodule

`default_nettype wire

//--- saturn_pkg.sv
//////////////////////////////////////////////////////////////
// Shared widths, register codes, opcodes and bus word
// encodings for the Saturn field datapath.
//////////////////////////////////////////////////////////////

`default_nettype none

package saturn_pkg;

    localparam int REG_NIBBLES  = 16; // Nibbles in one working register.
    localparam int ADDR_NIBBLES = 5;  // Nibbles sent on the bus for an address.

    typedef logic [3:0] nibble_t;
    typedef logic [3:0] nibble_ptr_t;

    typedef enum logic [1:0] {
        REG_A = 2'd0,
        REG_B = 2'd1,
        REG_C = 2'd2,
        REG_D = 2'd3
    } reg_sel_e;

    // Field operations. OP_CONFIG goes to the bus sender instead of the ALU.
    typedef enum logic [2:0] {
        OP_ZERO   = 3'd0,
        OP_COPY   = 3'd1,
        OP_EXCH   = 3'd2,
        OP_LOAD   = 3'd3,
        OP_CONFIG = 3'd4
    } alu_op_e;

    typedef enum logic [3:0] {
        BUSCMD_PC_READ   = 4'h0,
        BUSCMD_CONFIGURE = 4'h8
    } buscmd_e;

    // A bus word is a two-bit tag above a 4-bit command code or data nibble.
    typedef logic [5:0] bus_word_t;

    localparam logic [1:0] BUS_TAG_DATA = 2'b00;
    localparam logic [1:0] BUS_TAG_CMD  = 2'b01;

endpackage

`default_nettype wire
